// ==== common/qp_context_pkg.sv ====
package qp_context_pkg;

  // Local QPNs run from QPN_BASE to QPN_BASE + MAX_QP - 1
  localparam int MAX_QP   = 4;
  localparam int QP_IDX_W = (MAX_QP > 1) ? $clog2(MAX_QP) : 1;
  localparam int QPN_BASE = 256;

  typedef logic [23:0] psn_t;
  typedef logic [23:0] qpn_t;

  typedef enum logic [2:0] {
    RESET    = 3'd0,
    INIT     = 3'd1,
    RTR      = 3'd2,
    RTS      = 3'd3,
    SQ_DRAIN = 3'd4,
    SQ_ERROR = 3'd5,
    ERROR    = 3'd6
  } qp_state_e;

  // One table entry, 235 bits
  typedef struct packed {
    qp_state_e   state;
    logic [31:0] rem_ip_addr;
    qpn_t        rem_qpn;
    qpn_t        loc_qpn;
    psn_t        rem_psn;
    psn_t        loc_psn;
    logic [63:0] rem_addr;
    logic [31:0] r_key;
    logic [7:0]  syndrome;
  } qp_context_t;

  function automatic logic qpn_in_range(qpn_t qpn);
    return (qpn >= QPN_BASE) && (qpn < QPN_BASE + MAX_QP);
  endfunction

  function automatic logic [QP_IDX_W-1:0] qpn_to_idx(qpn_t qpn);
    qpn_t offset;
    offset = qpn - qpn_t'(QPN_BASE);
    return offset[QP_IDX_W-1:0];
  endfunction

endpackage

// ==== common/roce_cmd_pkg.sv ====
package roce_cmd_pkg;

  // Host request codes on qp_init_req_type
  typedef enum logic [6:0] {
    OPEN_QP       = 7'd1,
    MODIFY_QP_RTS = 7'd2,
    CLOSE_QP      = 7'd3
  } qp_req_e;

  typedef enum logic [7:0] {
    RC_ACK = 8'h11
  } bth_opcode_e;

  // Syndrome stored when the host forces a QP into error
  localparam logic [7:0] SYN_FORCED_ERROR = 8'h9F;

  // Operations sent from the command FSM to the context table
  typedef enum logic [1:0] {
    OP_OPEN   = 2'd0,
    OP_TO_RTS = 2'd1,
    OP_CLOSE  = 2'd2,
    OP_ERROR  = 2'd3
  } qp_op_e;

  // Bit 1 flags an error
  typedef enum logic [1:0] {
    OK       = 2'd0,
    REJECTED = 2'd2
  } qp_status_e;

endpackage

// ==== common/qp_update_if.sv ====
`timescale 1ns/1ps

interface qp_update_if
  import qp_context_pkg::*, roce_cmd_pkg::*;
();

  logic                op_valid;
  qp_op_e              op;
  logic [QP_IDX_W-1:0] idx;
  qp_context_t         ctx_in;
  logic [7:0]          syndrome;

  // One status per op, none for OP_ERROR
  logic                status_valid;
  qp_status_e          status;

  modport fsm (
    output op_valid,
    output op,
    output idx,
    output ctx_in,
    output syndrome
  );

  modport ctx_table (
    input  op_valid,
    input  op,
    input  idx,
    input  ctx_in,
    input  syndrome,
    output status_valid,
    output status
  );

endinterface

// ==== qp_context/ack_psn_store.sv ====
`timescale 1ns/1ps

module ack_psn_store
  import qp_context_pkg::*;
(
  input  logic                clk,
  input  logic                rst_qp,

  input  logic                ack_wr_valid,
  input  logic [QP_IDX_W-1:0] ack_wr_idx,
  input  psn_t                ack_wr_psn,

  input  logic                rd_valid,
  input  logic [QP_IDX_W-1:0] rd_idx,
  output psn_t                acked_psn
);

  // Last positively acknowledged PSN per QP
  psn_t psn_mem [MAX_QP];

  always_ff @(posedge clk) begin
    if (rst_qp) begin
      for (int i = 0; i < MAX_QP; i++) begin
        psn_mem[i] <= '0;
      end
    end else if (ack_wr_valid) begin
      psn_mem[ack_wr_idx] <= ack_wr_psn;
    end
  end

  // Lines up with stage 1 of the context read
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      acked_psn <= psn_mem[rd_idx];
    end
  end

endmodule

// ==== qp_context/qp_context_table.sv ====
`timescale 1ns/1ps

module qp_context_table
  import qp_context_pkg::*, roce_cmd_pkg::*;
(
  input  logic                clk,
  input  logic                rst_qp,

  qp_update_if.ctx_table      upd,

  input  logic                qp_context_req,
  input  qpn_t                qp_local_qpn_req,

  output logic                qp_req_context_valid,
  output qp_state_e           qp_req_state,
  output logic [31:0]         qp_req_r_key,
  output qpn_t                qp_req_rem_qpn,
  output qpn_t                qp_req_loc_qpn,
  output psn_t                qp_req_rem_psn,
  output psn_t                qp_req_loc_psn,
  output logic [31:0]         qp_req_rem_ip_addr,
  output logic [63:0]         qp_req_rem_addr,
  output logic [7:0]          qp_req_syndrome,
  output psn_t                qp_req_acked_psn,

  input  psn_t                acked_psn,
  output logic                rd_valid,
  output logic [QP_IDX_W-1:0] rd_idx
);

  qp_context_t ctx_mem [MAX_QP];
  qp_context_t cur_ctx;
  logic        op_ok;

  logic                req_valid_q;
  logic [QP_IDX_W-1:0] req_idx_q;
  logic                rd_valid_s1;
  logic                rd_valid_s2;
  qp_context_t         rd_ctx_s1;
  qp_context_t         rd_ctx_s2;
  psn_t                rd_acked_s2;

  assign cur_ctx = ctx_mem[upd.idx];

  // Legal source state per operation
  always_comb begin
    case (upd.op)
      OP_OPEN:   op_ok = (cur_ctx.state == RESET);
      OP_TO_RTS: op_ok = (cur_ctx.state == INIT);
      OP_CLOSE:  op_ok = (cur_ctx.state != RESET);
      default:   op_ok = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_qp) begin
      for (int i = 0; i < MAX_QP; i++) begin
        ctx_mem[i] <= '0;
      end
      upd.status_valid <= 1'b0;
    end else begin
      upd.status_valid <= upd.op_valid && (upd.op != OP_ERROR);
      if (upd.op_valid && op_ok) begin
        case (upd.op)
          OP_OPEN: begin
            ctx_mem[upd.idx] <= upd.ctx_in;
          end
          OP_TO_RTS: begin
            ctx_mem[upd.idx].state <= RTS;
          end
          OP_CLOSE: begin
            ctx_mem[upd.idx].state    <= RESET;
            ctx_mem[upd.idx].syndrome <= 8'd0;
          end
          default: begin
            ctx_mem[upd.idx].state    <= ERROR;
            ctx_mem[upd.idx].syndrome <= upd.syndrome;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (upd.op_valid) begin
      if (op_ok) begin
        upd.status <= OK;
      end else begin
        upd.status <= REJECTED;
      end
    end
  end

  // Registered request launches the store read together with stage 1
  assign rd_valid = req_valid_q;
  assign rd_idx   = req_idx_q;

  always_ff @(posedge clk) begin
    if (rst_qp) begin
      req_valid_q <= 1'b0;
      rd_valid_s1 <= 1'b0;
      rd_valid_s2 <= 1'b0;
    end else begin
      req_valid_q <= qp_context_req && qpn_in_range(qp_local_qpn_req);
      rd_valid_s1 <= rd_valid;
      rd_valid_s2 <= rd_valid_s1;
    end
  end

  always_ff @(posedge clk) begin
    req_idx_q <= qpn_to_idx(qp_local_qpn_req);
  end

  // A write in the same cycle is not seen here
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      rd_ctx_s1 <= ctx_mem[rd_idx];
    end
    rd_ctx_s2   <= rd_ctx_s1;
    rd_acked_s2 <= acked_psn;
  end

  assign qp_req_context_valid = rd_valid_s2;
  assign qp_req_state         = rd_ctx_s2.state;
  assign qp_req_r_key         = rd_ctx_s2.r_key;
  assign qp_req_rem_qpn       = rd_ctx_s2.rem_qpn;
  assign qp_req_loc_qpn       = rd_ctx_s2.loc_qpn;
  assign qp_req_rem_psn       = rd_ctx_s2.rem_psn;
  assign qp_req_loc_psn       = rd_ctx_s2.loc_psn;
  assign qp_req_rem_ip_addr   = rd_ctx_s2.rem_ip_addr;
  assign qp_req_rem_addr      = rd_ctx_s2.rem_addr;
  assign qp_req_syndrome      = rd_ctx_s2.syndrome;
  assign qp_req_acked_psn     = rd_acked_s2;

endmodule

// ==== source/qp_cmd_fsm.sv ====
`timescale 1ns/1ps

module qp_cmd_fsm
  import qp_context_pkg::*, roce_cmd_pkg::*;
(
  input  logic                clk,
  input  logic                rst_qp,

  input  logic                qp_init_valid,
  input  qp_req_e             qp_init_req_type,
  input  logic [31:0]         qp_init_r_key,
  input  qpn_t                qp_init_rem_qpn,
  input  qpn_t                qp_init_loc_qpn,
  input  psn_t                qp_init_rem_psn,
  input  psn_t                qp_init_loc_psn,
  input  logic [31:0]         qp_init_rem_ip_addr,
  input  logic [63:0]         qp_init_rem_addr,

  input  logic                qp_close_valid,
  input  qpn_t                qp_close_loc_qpn,

  input  logic                s_roce_rx_bth_valid,
  input  logic [7:0]          s_roce_rx_bth_op_code,
  input  psn_t                s_roce_rx_bth_psn,
  input  qpn_t                s_roce_rx_bth_dest_qp,
  input  logic                s_roce_rx_aeth_valid,
  input  logic [7:0]          s_roce_rx_aeth_syndrome,

  qp_update_if.fsm            upd,

  output logic                ack_wr_valid,
  output logic [QP_IDX_W-1:0] ack_wr_idx,
  output psn_t                ack_wr_psn
);

  typedef enum logic {
    IDLE,
    ISSUE
  } fsm_state_e;

  fsm_state_e          state;
  logic                rx_ack;
  logic                fatal_nak;
  logic                pos_ack;
  logic                close_hit;
  logic                init_hit;
  logic                accept;
  logic                take_init;
  qp_op_e              next_op;
  logic [QP_IDX_W-1:0] next_idx;
  logic [7:0]          next_syn;

  assign rx_ack = s_roce_rx_bth_valid && s_roce_rx_aeth_valid &&
                  (s_roce_rx_bth_op_code == RC_ACK) &&
                  qpn_in_range(s_roce_rx_bth_dest_qp);

  // NAK class 3 with a nonzero code is fatal
  assign fatal_nak = rx_ack && (s_roce_rx_aeth_syndrome[6:5] == 2'b11) &&
                     (s_roce_rx_aeth_syndrome[4:0] != 5'd0);
  assign pos_ack   = rx_ack && (s_roce_rx_aeth_syndrome[6:5] == 2'b00);

  assign close_hit = qp_close_valid && qpn_in_range(qp_close_loc_qpn);
  assign init_hit  = qp_init_valid && qpn_in_range(qp_init_loc_qpn);

  // Close beats fatal NAK beats host command
  always_comb begin
    accept    = 1'b0;
    take_init = 1'b0;
    next_op   = OP_ERROR;
    next_idx  = '0;
    next_syn  = 8'd0;
    if (state == IDLE) begin
      if (close_hit) begin
        accept   = 1'b1;
        next_idx = qpn_to_idx(qp_close_loc_qpn);
        next_syn = SYN_FORCED_ERROR;
      end else if (fatal_nak) begin
        accept   = 1'b1;
        next_idx = qpn_to_idx(s_roce_rx_bth_dest_qp);
        next_syn = s_roce_rx_aeth_syndrome;
      end else if (init_hit) begin
        next_idx = qpn_to_idx(qp_init_loc_qpn);
        case (qp_init_req_type)
          OPEN_QP: begin
            accept  = 1'b1;
            next_op = OP_OPEN;
          end
          MODIFY_QP_RTS: begin
            accept  = 1'b1;
            next_op = OP_TO_RTS;
          end
          CLOSE_QP: begin
            accept  = 1'b1;
            next_op = OP_CLOSE;
          end
          default: accept = 1'b0;
        endcase
        take_init = accept;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_qp) begin
      state        <= IDLE;
      upd.op_valid <= 1'b0;
      ack_wr_valid <= 1'b0;
    end else begin
      upd.op_valid <= (state == ISSUE);
      ack_wr_valid <= pos_ack;
      case (state)
        IDLE: begin
          if (accept) begin
            state <= ISSUE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      upd.op       <= next_op;
      upd.idx      <= next_idx;
      upd.syndrome <= next_syn;
    end
    if (take_init) begin
      upd.ctx_in <= '{
        state:       INIT,
        rem_ip_addr: qp_init_rem_ip_addr,
        rem_qpn:     qp_init_rem_qpn,
        loc_qpn:     qp_init_loc_qpn,
        rem_psn:     qp_init_rem_psn,
        loc_psn:     qp_init_loc_psn,
        rem_addr:    qp_init_rem_addr,
        r_key:       qp_init_r_key,
        syndrome:    8'd0
      };
    end
    if (pos_ack) begin
      ack_wr_idx <= qpn_to_idx(s_roce_rx_bth_dest_qp);
      ack_wr_psn <= s_roce_rx_bth_psn;
    end
  end

endmodule

// ==== source/qp_state_top.sv ====
`timescale 1ns/1ps

module qp_state_top
  import qp_context_pkg::*, roce_cmd_pkg::*;
(
  input  logic        clk,
  input  logic        rst_qp,

  input  logic        qp_init_valid,
  input  qp_req_e     qp_init_req_type,
  input  logic [31:0] qp_init_r_key,
  input  qpn_t        qp_init_rem_qpn,
  input  qpn_t        qp_init_loc_qpn,
  input  psn_t        qp_init_rem_psn,
  input  psn_t        qp_init_loc_psn,
  input  logic [31:0] qp_init_rem_ip_addr,
  input  logic [63:0] qp_init_rem_addr,

  output logic        qp_init_status_valid,
  output qp_status_e  qp_init_status,

  input  logic        qp_close_valid,
  input  qpn_t        qp_close_loc_qpn,

  input  logic        qp_context_req,
  input  qpn_t        qp_local_qpn_req,

  output logic        qp_req_context_valid,
  output qp_state_e   qp_req_state,
  output logic [31:0] qp_req_r_key,
  output qpn_t        qp_req_rem_qpn,
  output qpn_t        qp_req_loc_qpn,
  output psn_t        qp_req_rem_psn,
  output psn_t        qp_req_loc_psn,
  output logic [31:0] qp_req_rem_ip_addr,
  output logic [63:0] qp_req_rem_addr,
  output logic [7:0]  qp_req_syndrome,
  output psn_t        qp_req_acked_psn,

  input  logic        s_roce_rx_bth_valid,
  input  logic [7:0]  s_roce_rx_bth_op_code,
  input  psn_t        s_roce_rx_bth_psn,
  input  qpn_t        s_roce_rx_bth_dest_qp,
  input  logic        s_roce_rx_aeth_valid,
  input  logic [7:0]  s_roce_rx_aeth_syndrome
);

  logic                ack_wr_valid;
  logic [QP_IDX_W-1:0] ack_wr_idx;
  psn_t                ack_wr_psn;
  logic                rd_valid;
  logic [QP_IDX_W-1:0] rd_idx;
  psn_t                acked_psn;

  qp_update_if upd_if ();

  assign qp_init_status_valid = upd_if.status_valid;
  assign qp_init_status       = upd_if.status;

  qp_cmd_fsm qp_cmd_fsm_inst (
    .clk                     (clk),
    .rst_qp                  (rst_qp),
    .qp_init_valid           (qp_init_valid),
    .qp_init_req_type        (qp_init_req_type),
    .qp_init_r_key           (qp_init_r_key),
    .qp_init_rem_qpn         (qp_init_rem_qpn),
    .qp_init_loc_qpn         (qp_init_loc_qpn),
    .qp_init_rem_psn         (qp_init_rem_psn),
    .qp_init_loc_psn         (qp_init_loc_psn),
    .qp_init_rem_ip_addr     (qp_init_rem_ip_addr),
    .qp_init_rem_addr        (qp_init_rem_addr),
    .qp_close_valid          (qp_close_valid),
    .qp_close_loc_qpn        (qp_close_loc_qpn),
    .s_roce_rx_bth_valid     (s_roce_rx_bth_valid),
    .s_roce_rx_bth_op_code   (s_roce_rx_bth_op_code),
    .s_roce_rx_bth_psn       (s_roce_rx_bth_psn),
    .s_roce_rx_bth_dest_qp   (s_roce_rx_bth_dest_qp),
    .s_roce_rx_aeth_valid    (s_roce_rx_aeth_valid),
    .s_roce_rx_aeth_syndrome (s_roce_rx_aeth_syndrome),
    .upd                     (upd_if.fsm),
    .ack_wr_valid            (ack_wr_valid),
    .ack_wr_idx              (ack_wr_idx),
    .ack_wr_psn              (ack_wr_psn)
  );

  qp_context_table qp_context_table_inst (
    .clk                  (clk),
    .rst_qp               (rst_qp),
    .upd                  (upd_if.ctx_table),
    .qp_context_req       (qp_context_req),
    .qp_local_qpn_req     (qp_local_qpn_req),
    .qp_req_context_valid (qp_req_context_valid),
    .qp_req_state         (qp_req_state),
    .qp_req_r_key         (qp_req_r_key),
    .qp_req_rem_qpn       (qp_req_rem_qpn),
    .qp_req_loc_qpn       (qp_req_loc_qpn),
    .qp_req_rem_psn       (qp_req_rem_psn),
    .qp_req_loc_psn       (qp_req_loc_psn),
    .qp_req_rem_ip_addr   (qp_req_rem_ip_addr),
    .qp_req_rem_addr      (qp_req_rem_addr),
    .qp_req_syndrome      (qp_req_syndrome),
    .qp_req_acked_psn     (qp_req_acked_psn),
    .acked_psn            (acked_psn),
    .rd_valid             (rd_valid),
    .rd_idx               (rd_idx)
  );

  ack_psn_store ack_psn_store_inst (
    .clk          (clk),
    .rst_qp       (rst_qp),
    .ack_wr_valid (ack_wr_valid),
    .ack_wr_idx   (ack_wr_idx),
    .ack_wr_psn   (ack_wr_psn),
    .rd_valid     (rd_valid),
    .rd_idx       (rd_idx),
    .acked_psn    (acked_psn)
  );

endmodule

// ==== testbench/tb_qp_state.sv ====
`timescale 1ns/1ps

module tb_qp_state
  import qp_context_pkg::*, roce_cmd_pkg::*;
();

  localparam int CYCLE_LIMIT = 2000;

  logic        clk;
  logic        rst_qp;
  logic        qp_init_valid;
  qp_req_e     qp_init_req_type;
  logic [31:0] qp_init_r_key;
  qpn_t        qp_init_rem_qpn;
  qpn_t        qp_init_loc_qpn;
  psn_t        qp_init_rem_psn;
  psn_t        qp_init_loc_psn;
  logic [31:0] qp_init_rem_ip_addr;
  logic [63:0] qp_init_rem_addr;
  logic        qp_init_status_valid;
  qp_status_e  qp_init_status;
  logic        qp_close_valid;
  qpn_t        qp_close_loc_qpn;
  logic        qp_context_req;
  qpn_t        qp_local_qpn_req;
  logic        qp_req_context_valid;
  qp_state_e   qp_req_state;
  logic [31:0] qp_req_r_key;
  qpn_t        qp_req_rem_qpn;
  qpn_t        qp_req_loc_qpn;
  psn_t        qp_req_rem_psn;
  psn_t        qp_req_loc_psn;
  logic [31:0] qp_req_rem_ip_addr;
  logic [63:0] qp_req_rem_addr;
  logic [7:0]  qp_req_syndrome;
  psn_t        qp_req_acked_psn;
  logic        s_roce_rx_bth_valid;
  logic [7:0]  s_roce_rx_bth_op_code;
  psn_t        s_roce_rx_bth_psn;
  qpn_t        s_roce_rx_bth_dest_qp;
  logic        s_roce_rx_aeth_valid;
  logic [7:0]  s_roce_rx_aeth_syndrome;

  // Expected state of every QP
  qp_context_t exp_ctx [MAX_QP];
  psn_t        exp_acked [MAX_QP];

  integer seed = 32'hfb832a3f;
  int     error_count = 0;
  int     check_count = 0;
  int     cycle_count = 0;

  qp_state_top qp_state_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic make_fields(input int qpn, output qp_context_t f);
    f             = '0;
    f.state       = INIT;
    f.rem_ip_addr = $random(seed);
    f.rem_qpn     = $random(seed);
    f.loc_qpn     = qpn_t'(qpn);
    f.rem_psn     = $random(seed);
    f.loc_psn     = $random(seed);
    f.rem_addr    = {$random(seed), $random(seed)};
    f.r_key       = $random(seed);
  endtask

  task automatic compare_read(input int idx);
    check_value($sformatf("QP%0d state", idx), qp_req_state, exp_ctx[idx].state);
    check_value($sformatf("QP%0d r_key", idx), qp_req_r_key, exp_ctx[idx].r_key);
    check_value($sformatf("QP%0d rem_qpn", idx), qp_req_rem_qpn, exp_ctx[idx].rem_qpn);
    check_value($sformatf("QP%0d loc_qpn", idx), qp_req_loc_qpn, exp_ctx[idx].loc_qpn);
    check_value($sformatf("QP%0d rem_psn", idx), qp_req_rem_psn, exp_ctx[idx].rem_psn);
    check_value($sformatf("QP%0d loc_psn", idx), qp_req_loc_psn, exp_ctx[idx].loc_psn);
    check_value($sformatf("QP%0d rem_ip", idx), qp_req_rem_ip_addr,
                exp_ctx[idx].rem_ip_addr);
    check_value($sformatf("QP%0d rem_addr", idx), qp_req_rem_addr, exp_ctx[idx].rem_addr);
    check_value($sformatf("QP%0d syndrome", idx), qp_req_syndrome, exp_ctx[idx].syndrome);
    check_value($sformatf("QP%0d acked_psn", idx), qp_req_acked_psn, exp_acked[idx]);
  endtask

  // Neither a status nor a read result may show up for 4 cycles
  task automatic expect_silence(input string what);
    for (int i = 0; i < 4; i++) begin
      if (qp_init_status_valid || qp_req_context_valid) begin
        error_count++;
        $display("Unexpected output at %0t ns after %s", $time, what);
      end
      @(negedge clk);
    end
  endtask

  task automatic drive_command(input qp_req_e req, input int qpn, input qp_context_t f);
    @(negedge clk);
    qp_init_valid       = 1'b1;
    qp_init_req_type    = req;
    qp_init_loc_qpn     = qpn_t'(qpn);
    qp_init_rem_qpn     = f.rem_qpn;
    qp_init_rem_psn     = f.rem_psn;
    qp_init_loc_psn     = f.loc_psn;
    qp_init_rem_ip_addr = f.rem_ip_addr;
    qp_init_rem_addr    = f.rem_addr;
    qp_init_r_key       = f.r_key;
    @(negedge clk);
    qp_init_valid = 1'b0;
  endtask

  task automatic run_command(input qp_req_e req, input int qpn);
    qp_context_t f;
    qp_status_e  exp_status;
    int          idx;
    int          waited;
    idx = qpn - QPN_BASE;
    make_fields(qpn, f);
    exp_status = REJECTED;
    if (req == OPEN_QP && exp_ctx[idx].state == RESET) begin
      exp_ctx[idx] = f;
      exp_status   = OK;
    end else if (req == MODIFY_QP_RTS && exp_ctx[idx].state == INIT) begin
      exp_ctx[idx].state = RTS;
      exp_status         = OK;
    end else if (req == CLOSE_QP && exp_ctx[idx].state != RESET) begin
      exp_ctx[idx].state    = RESET;
      exp_ctx[idx].syndrome = 8'd0;
      exp_status            = OK;
    end
    drive_command(req, qpn, f);
    waited = 1;
    while (!qp_init_status_valid && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (!qp_init_status_valid) begin
      error_count++;
      $display("No status within 4 cycles for command %0d on QPN %0d", req, qpn);
    end else begin
      check_value($sformatf("status of command %0d on QPN %0d", req, qpn),
                  qp_init_status, exp_status);
    end
  endtask

  task automatic read_context(input int qpn);
    int waited;
    @(negedge clk);
    qp_context_req   = 1'b1;
    qp_local_qpn_req = qpn_t'(qpn);
    @(negedge clk);
    qp_context_req = 1'b0;
    waited = 1;
    while (!qp_req_context_valid && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (!qp_req_context_valid) begin
      error_count++;
      $display("Read of QPN %0d returned no valid within 4 cycles", qpn);
    end else begin
      check_value($sformatf("read latency for QPN %0d", qpn), waited - 1, 2);
      compare_read(qpn - QPN_BASE);
    end
  endtask

  // Two requests on consecutive cycles
  task automatic read_pair(input int qpn_a, input int qpn_b);
    @(negedge clk);
    qp_context_req   = 1'b1;
    qp_local_qpn_req = qpn_t'(qpn_a);
    @(negedge clk);
    qp_local_qpn_req = qpn_t'(qpn_b);
    @(negedge clk);
    qp_context_req = 1'b0;
    check_value("read valid one cycle early", qp_req_context_valid, 1'b0);
    @(negedge clk);
    check_value("first read valid", qp_req_context_valid, 1'b1);
    compare_read(qpn_a - QPN_BASE);
    @(negedge clk);
    check_value("second read valid", qp_req_context_valid, 1'b1);
    compare_read(qpn_b - QPN_BASE);
  endtask

  task automatic send_rx(input logic [7:0] opcode, input int qpn, input psn_t psn,
                         input logic aeth_valid, input logic [7:0] syn);
    int idx;
    idx = qpn - QPN_BASE;
    if (opcode == RC_ACK && aeth_valid) begin
      if (syn[6:5] == 2'b00) begin
        exp_acked[idx] = psn;
      end else if (syn[6:5] == 2'b11 && syn[4:0] != 5'd0) begin
        exp_ctx[idx].state    = ERROR;
        exp_ctx[idx].syndrome = syn;
      end
    end
    @(negedge clk);
    s_roce_rx_bth_valid     = 1'b1;
    s_roce_rx_bth_op_code   = opcode;
    s_roce_rx_bth_psn       = psn;
    s_roce_rx_bth_dest_qp   = qpn_t'(qpn);
    s_roce_rx_aeth_valid    = aeth_valid;
    s_roce_rx_aeth_syndrome = syn;
    @(negedge clk);
    s_roce_rx_bth_valid  = 1'b0;
    s_roce_rx_aeth_valid = 1'b0;
    expect_silence("a received packet");
  endtask

  task automatic force_error(input int qpn);
    exp_ctx[qpn - QPN_BASE].state    = ERROR;
    exp_ctx[qpn - QPN_BASE].syndrome = SYN_FORCED_ERROR;
    @(negedge clk);
    qp_close_valid   = 1'b1;
    qp_close_loc_qpn = qpn_t'(qpn);
    @(negedge clk);
    qp_close_valid = 1'b0;
    expect_silence("a close request");
  endtask

  task automatic out_of_range(input int qpn);
    qp_context_t f;
    make_fields(qpn, f);
    drive_command(OPEN_QP, qpn, f);
    expect_silence($sformatf("a command on QPN %0d", qpn));
    @(negedge clk);
    qp_context_req   = 1'b1;
    qp_local_qpn_req = qpn_t'(qpn);
    @(negedge clk);
    qp_context_req = 1'b0;
    expect_silence($sformatf("a read of QPN %0d", qpn));
  endtask

  initial begin
    psn_t psn;
    rst_qp                  = 1'b1;
    qp_init_valid           = 1'b0;
    qp_init_req_type        = OPEN_QP;
    qp_init_r_key           = '0;
    qp_init_rem_qpn         = '0;
    qp_init_loc_qpn         = '0;
    qp_init_rem_psn         = '0;
    qp_init_loc_psn         = '0;
    qp_init_rem_ip_addr     = '0;
    qp_init_rem_addr        = '0;
    qp_close_valid          = 1'b0;
    qp_close_loc_qpn        = '0;
    qp_context_req          = 1'b0;
    qp_local_qpn_req        = '0;
    s_roce_rx_bth_valid     = 1'b0;
    s_roce_rx_bth_op_code   = '0;
    s_roce_rx_bth_psn       = '0;
    s_roce_rx_bth_dest_qp   = '0;
    s_roce_rx_aeth_valid    = 1'b0;
    s_roce_rx_aeth_syndrome = '0;
    for (int i = 0; i < MAX_QP; i++) begin
      exp_ctx[i]   = '0;
      exp_acked[i] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_qp = 1'b0;

    // Open every QP and read it back
    read_context(QPN_BASE);
    for (int i = 0; i < MAX_QP; i++) begin
      run_command(OPEN_QP, QPN_BASE + i);
      read_context(QPN_BASE + i);
    end
    read_pair(QPN_BASE, QPN_BASE + 1);
    read_pair(QPN_BASE + 2, QPN_BASE + 3);

    // Modify to RTS, then illegal transitions
    run_command(MODIFY_QP_RTS, QPN_BASE);
    read_context(QPN_BASE);
    run_command(MODIFY_QP_RTS, QPN_BASE);
    run_command(OPEN_QP, QPN_BASE);
    read_context(QPN_BASE);

    // Positive ACK, then packets that must be ignored
    psn = $random(seed);
    send_rx(RC_ACK, QPN_BASE + 2, psn, 1'b1, 8'h00);
    for (int i = 0; i < MAX_QP; i++) begin
      read_context(QPN_BASE + i);
    end
    psn = $random(seed);
    send_rx(8'h0C, QPN_BASE + 2, psn, 1'b1, 8'h00);
    send_rx(RC_ACK, QPN_BASE + 2, psn + 24'd1, 1'b0, 8'h00);
    read_context(QPN_BASE + 2);

    // NAKs and forced error
    send_rx(RC_ACK, QPN_BASE + 3, $random(seed), 1'b1, 8'h60);
    read_context(QPN_BASE + 3);
    send_rx(RC_ACK, QPN_BASE + 3, $random(seed), 1'b1, 8'h6A);
    read_context(QPN_BASE + 3);
    force_error(QPN_BASE + 1);
    read_context(QPN_BASE + 1);
    read_context(QPN_BASE + 3);

    // Close and out-of-range QPNs
    run_command(CLOSE_QP, QPN_BASE);
    read_context(QPN_BASE);
    run_command(CLOSE_QP, QPN_BASE);
    run_command(CLOSE_QP, QPN_BASE + 3);
    read_context(QPN_BASE + 3);
    out_of_range(QPN_BASE - 1);
    out_of_range(QPN_BASE + MAX_QP);

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
common/qp_context_pkg.sv
common/roce_cmd_pkg.sv
common/qp_update_if.sv
qp_context/ack_psn_store.sv
qp_context/qp_context_table.sv
source/qp_cmd_fsm.sv
source/qp_state_top.sv
testbench/tb_qp_state.sv
